//--- logic/mem_test_pkg.sv
package mem_test_pkg;

    // Memory word and byte enable
    localparam int DATA_WIDTH = 64;
    localparam int BE_WIDTH = 8;

    // 256 words in the bank
    localparam int ADDR_WIDTH = 8;

    // Bursts of 1 to 4 beats fit in this width
    localparam int BURST_WIDTH = 3;

    // The address self test covers the lowest 16 words
    localparam int TEST_ADDR_BITS = 4;

    // Cycles from a read leaving the queue to readdatavalid
    localparam int READ_LATENCY = 2;

    // Command queue entries and the pointer width that indexes them
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    localparam int ERR_WIDTH = 32;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_t;

    typedef enum logic [2:0] {
        IDLE,
        TEST_WRITE,
        TEST_READ,
        RD_REQ,
        RD_RSP,
        WR_REQ,
        WR_RSP
    } fsm_state_t;

endpackage

//--- logic/mem_cmd_fsm.sv
`timescale 1ns/1ps

module mem_cmd_fsm
    import mem_test_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sw_write,
    input  logic                    sw_read,
    input  logic [ADDR_WIDTH-1:0]   sw_address,
    input  logic [DATA_WIDTH-1:0]   sw_writedata,
    input  logic [BE_WIDTH-1:0]     sw_byteenable,
    input  logic [BURST_WIDTH-1:0]  sw_burstcount,
    input  logic                    mem_testmode,
    input  logic                    rdwr_reset,
    input  logic                    mem_error_clr,
    input  logic                    cmd_waitrequest,
    input  logic                    readdatavalid,
    input  logic [DATA_WIDTH-1:0]   readdata,
    output logic                    cmd_valid,
    output mem_op_t                 cmd_op,
    output logic [ADDR_WIDTH-1:0]   cmd_address,
    output logic [DATA_WIDTH-1:0]   cmd_writedata,
    output logic [BE_WIDTH-1:0]     cmd_byteenable,
    output logic                    ready_for_sw_cmd,
    output fsm_state_t              fsm_state,
    output logic                    addr_test_done,
    output logic                    addr_test_pass,
    output logic [1:0]              rdwr_done,
    output logic [DATA_WIDTH-1:0]   sw_readdata,
    output logic [ERR_WIDTH-1:0]    mem_errors
);

    fsm_state_t              state;
    logic [BURST_WIDTH-1:0]  beat;
    logic [BURST_WIDTH-1:0]  burst_len;
    logic [TEST_ADDR_BITS:0] rd_outstanding;
    logic [TEST_ADDR_BITS:0] rd_outstanding_next;
    logic                    cmd_accept;
    logic                    rd_accept;
    logic                    last_beat;
    logic                    last_test_addr;
    logic                    test_fail;
    logic                    test_word_bad;
    logic                    start_test;
    logic [DATA_WIDTH-1:0]   byte_mask;

    assign fsm_state = state;
    assign cmd_accept = cmd_valid && !cmd_waitrequest;
    assign rd_accept = cmd_accept && (cmd_op == OP_READ);
    assign last_beat = (beat + BURST_WIDTH'(1)) == burst_len;
    assign last_test_addr = &cmd_address[TEST_ADDR_BITS-1:0];
    assign test_word_bad = readdatavalid && (readdata != sw_writedata);
    assign start_test = mem_testmode && !addr_test_done;

    // Expand the software byte enable to a bit mask for the data check
    always_comb
    begin
        for (int i = 0; i < BE_WIDTH; i++)
        begin
            byte_mask[i*8 +: 8] = {8{sw_byteenable[i]}};
        end
    end

    // Reads accepted by the queue minus responses already returned
    always_comb
    begin
        case ({rd_accept, readdatavalid})
            2'b10:   rd_outstanding_next = rd_outstanding + (TEST_ADDR_BITS + 1)'(1);
            2'b01:   rd_outstanding_next = rd_outstanding - (TEST_ADDR_BITS + 1)'(1);
            default: rd_outstanding_next = rd_outstanding;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
            ready_for_sw_cmd <= 1'b0;
            cmd_valid <= 1'b0;
            cmd_op <= OP_READ;
            cmd_address <= '0;
            beat <= '0;
            burst_len <= '0;
            addr_test_done <= 1'b0;
            addr_test_pass <= 1'b0;
            test_fail <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    ready_for_sw_cmd <= 1'b1;
                    beat <= '0;
                    // The self test runs once and takes priority over software
                    if (start_test)
                    begin
                        state <= TEST_WRITE;
                        ready_for_sw_cmd <= 1'b0;
                        cmd_valid <= 1'b1;
                        cmd_op <= OP_WRITE;
                        cmd_address <= '0;
                        test_fail <= 1'b0;
                    end
                    else if (ready_for_sw_cmd && sw_write)
                    begin
                        state <= WR_REQ;
                        ready_for_sw_cmd <= 1'b0;
                        cmd_valid <= 1'b1;
                        cmd_op <= OP_WRITE;
                        cmd_address <= sw_address;
                        burst_len <= sw_burstcount;
                    end
                    else if (ready_for_sw_cmd && sw_read)
                    begin
                        state <= RD_REQ;
                        ready_for_sw_cmd <= 1'b0;
                        cmd_valid <= 1'b1;
                        cmd_op <= OP_READ;
                        cmd_address <= sw_address;
                        burst_len <= sw_burstcount;
                    end
                end

                TEST_WRITE:
                begin
                    if (cmd_accept)
                    begin
                        if (last_test_addr)
                        begin
                            state <= TEST_READ;
                            cmd_op <= OP_READ;
                            cmd_address <= '0;
                        end
                        else
                        begin
                            cmd_address <= cmd_address + ADDR_WIDTH'(1);
                        end
                    end
                end

                TEST_READ:
                begin
                    if (cmd_accept)
                    begin
                        if (last_test_addr)
                            cmd_valid <= 1'b0;
                        else
                            cmd_address <= cmd_address + ADDR_WIDTH'(1);
                    end
                    if (test_word_bad)
                        test_fail <= 1'b1;
                    // All reads issued and the last response is in
                    if (!cmd_valid && (rd_outstanding_next == '0))
                    begin
                        state <= IDLE;
                        addr_test_done <= 1'b1;
                        addr_test_pass <= !(test_fail || test_word_bad);
                    end
                end

                WR_REQ, RD_REQ:
                begin
                    // Stall the beat counter under back-pressure
                    if (cmd_accept)
                    begin
                        if (last_beat)
                        begin
                            cmd_valid <= 1'b0;
                            state <= (state == WR_REQ) ? WR_RSP : RD_RSP;
                        end
                        else
                        begin
                            beat <= beat + BURST_WIDTH'(1);
                            cmd_address <= cmd_address + ADDR_WIDTH'(1);
                        end
                    end
                end

                // Writes are posted, so completion follows the last accepted beat
                WR_RSP:
                begin
                    state <= IDLE;
                end

                RD_RSP:
                begin
                    if (rd_outstanding_next == '0)
                        state <= IDLE;
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data and byte enable are captured on the way out of IDLE
    always_ff @(posedge clk)
    begin
        if (state == IDLE)
        begin
            cmd_writedata <= sw_writedata;
            cmd_byteenable <= start_test ? '1 : sw_byteenable;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_outstanding <= '0;
        else
            rd_outstanding <= rd_outstanding_next;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || rdwr_reset)
        begin
            rdwr_done <= 2'b00;
        end
        else
        begin
            if (state == WR_RSP)
                rdwr_done[0] <= 1'b1;
            if ((state == RD_RSP) && (rd_outstanding_next == '0))
                rdwr_done[1] <= 1'b1;
        end
    end

    // Count every returned word that differs from the write data in an enabled byte
    always_ff @(posedge clk)
    begin
        if (!reset_n || mem_error_clr)
            mem_errors <= '0;
        else if (readdatavalid && ((readdata & byte_mask) != (sw_writedata & byte_mask)))
            mem_errors <= mem_errors + ERR_WIDTH'(1);
    end

    always_ff @(posedge clk)
    begin
        if (readdatavalid)
            sw_readdata <= readdata;
    end

    // A stalled command must reach the queue unchanged
    a_cmd_stable: assert property (@(posedge clk) disable iff (!reset_n)
        cmd_valid && cmd_waitrequest |=> cmd_valid && $stable(cmd_op) &&
        $stable(cmd_address) && $stable(cmd_writedata) && $stable(cmd_byteenable))
        else $error("command changed while waitrequest was high");

    // The bank never returns more words than reads the queue accepted
    a_rd_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        readdatavalid |-> rd_outstanding != '0)
        else $error("read response without an outstanding read");

endmodule

//--- logic/mem_cmd_fifo.sv
`timescale 1ns/1ps

module mem_cmd_fifo
    import mem_test_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   cmd_valid,
    input  mem_op_t                cmd_op,
    input  logic [ADDR_WIDTH-1:0]  cmd_address,
    input  logic [DATA_WIDTH-1:0]  cmd_writedata,
    input  logic [BE_WIDTH-1:0]    cmd_byteenable,
    output logic                   cmd_waitrequest,
    output logic                   q_valid,
    output mem_op_t                q_op,
    output logic [ADDR_WIDTH-1:0]  q_address,
    output logic [DATA_WIDTH-1:0]  q_writedata,
    output logic [BE_WIDTH-1:0]    q_byteenable
);

    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      full;
    logic                      push;
    logic                      pop;

    mem_op_t                   op_q   [FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0]     addr_q [FIFO_DEPTH];
    logic [DATA_WIDTH-1:0]     data_q [FIFO_DEPTH];
    logic [BE_WIDTH-1:0]       be_q   [FIFO_DEPTH];

    assign full = count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH);
    assign cmd_waitrequest = full;
    assign push = cmd_valid && !full;

    // The bank takes one entry per cycle, so the head leaves whenever present
    assign pop = count != '0;
    assign q_valid = pop;
    assign q_op = op_q[rd_ptr];
    assign q_address = addr_q[rd_ptr];
    assign q_writedata = data_q[rd_ptr];
    assign q_byteenable = be_q[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + FIFO_PTR_WIDTH'(1);
            if (pop)
                rd_ptr <= rd_ptr + FIFO_PTR_WIDTH'(1);
            case ({push, pop})
                2'b10:   count <= count + (FIFO_PTR_WIDTH + 1)'(1);
                2'b01:   count <= count - (FIFO_PTR_WIDTH + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            op_q[wr_ptr] <= cmd_op;
            addr_q[wr_ptr] <= cmd_address;
            data_q[wr_ptr] <= cmd_writedata;
            be_q[wr_ptr] <= cmd_byteenable;
        end
    end

    // The write pointer leads the read pointer by the fill level, so no push lands on the head
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        (count <= (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH)) &&
        (FIFO_PTR_WIDTH'(wr_ptr - rd_ptr) == count[FIFO_PTR_WIDTH-1:0]))
        else $error("command queue accepted a push while full");

endmodule

//--- logic/local_mem_bank.sv
`timescale 1ns/1ps

module local_mem_bank
    import mem_test_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   q_valid,
    input  mem_op_t                q_op,
    input  logic [ADDR_WIDTH-1:0]  q_address,
    input  logic [DATA_WIDTH-1:0]  q_writedata,
    input  logic [BE_WIDTH-1:0]    q_byteenable,
    output logic                   readdatavalid,
    output logic [DATA_WIDTH-1:0]  readdata
);

    logic [DATA_WIDTH-1:0]   mem [2**ADDR_WIDTH];
    logic [READ_LATENCY-1:0] valid_pipe;
    logic [DATA_WIDTH-1:0]   data_pipe [READ_LATENCY];
    logic                    wr_en;
    logic                    rd_en;

    assign wr_en = q_valid && (q_op == OP_WRITE);
    assign rd_en = q_valid && (q_op == OP_READ);

    // Only the enabled bytes of the stored word are replaced
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int i = 0; i < BE_WIDTH; i++)
            begin
                if (q_byteenable[i])
                    mem[q_address][i*8 +: 8] <= q_writedata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[READ_LATENCY-2:0], rd_en};
    end

    // The first stage reads the array and the rest only delay the word
    always_ff @(posedge clk)
    begin
        if (rd_en)
            data_pipe[0] <= mem[q_address];
        for (int i = 1; i < READ_LATENCY; i++)
        begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign readdatavalid = valid_pipe[READ_LATENCY-1];
    assign readdata = data_pipe[READ_LATENCY-1];

endmodule

//--- logic/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top
    import mem_test_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sw_write,
    input  logic                    sw_read,
    input  logic [ADDR_WIDTH-1:0]   sw_address,
    input  logic [DATA_WIDTH-1:0]   sw_writedata,
    input  logic [BE_WIDTH-1:0]     sw_byteenable,
    input  logic [BURST_WIDTH-1:0]  sw_burstcount,
    input  logic                    mem_testmode,
    input  logic                    rdwr_reset,
    input  logic                    mem_error_clr,
    output logic                    ready_for_sw_cmd,
    output fsm_state_t              fsm_state,
    output logic                    addr_test_done,
    output logic                    addr_test_pass,
    output logic [1:0]              rdwr_done,
    output logic [DATA_WIDTH-1:0]   sw_readdata,
    output logic [ERR_WIDTH-1:0]    mem_errors
);

    logic                   cmd_valid;
    mem_op_t                cmd_op;
    logic [ADDR_WIDTH-1:0]  cmd_address;
    logic [DATA_WIDTH-1:0]  cmd_writedata;
    logic [BE_WIDTH-1:0]    cmd_byteenable;
    logic                   cmd_waitrequest;
    logic                   q_valid;
    mem_op_t                q_op;
    logic [ADDR_WIDTH-1:0]  q_address;
    logic [DATA_WIDTH-1:0]  q_writedata;
    logic [BE_WIDTH-1:0]    q_byteenable;
    logic                   readdatavalid;
    logic [DATA_WIDTH-1:0]  readdata;

    mem_cmd_fsm u_mem_cmd_fsm (
        .clk              (clk),
        .reset_n          (reset_n),
        .sw_write         (sw_write),
        .sw_read          (sw_read),
        .sw_address       (sw_address),
        .sw_writedata     (sw_writedata),
        .sw_byteenable    (sw_byteenable),
        .sw_burstcount    (sw_burstcount),
        .mem_testmode     (mem_testmode),
        .rdwr_reset       (rdwr_reset),
        .mem_error_clr    (mem_error_clr),
        .cmd_waitrequest  (cmd_waitrequest),
        .readdatavalid    (readdatavalid),
        .readdata         (readdata),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_address      (cmd_address),
        .cmd_writedata    (cmd_writedata),
        .cmd_byteenable   (cmd_byteenable),
        .ready_for_sw_cmd (ready_for_sw_cmd),
        .fsm_state        (fsm_state),
        .addr_test_done   (addr_test_done),
        .addr_test_pass   (addr_test_pass),
        .rdwr_done        (rdwr_done),
        .sw_readdata      (sw_readdata),
        .mem_errors       (mem_errors)
    );

    mem_cmd_fifo u_mem_cmd_fifo (
        .clk             (clk),
        .reset_n         (reset_n),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_address     (cmd_address),
        .cmd_writedata   (cmd_writedata),
        .cmd_byteenable  (cmd_byteenable),
        .cmd_waitrequest (cmd_waitrequest),
        .q_valid         (q_valid),
        .q_op            (q_op),
        .q_address       (q_address),
        .q_writedata     (q_writedata),
        .q_byteenable    (q_byteenable)
    );

    local_mem_bank u_local_mem_bank (
        .clk           (clk),
        .reset_n       (reset_n),
        .q_valid       (q_valid),
        .q_op          (q_op),
        .q_address     (q_address),
        .q_writedata   (q_writedata),
        .q_byteenable  (q_byteenable),
        .readdatavalid (readdatavalid),
        .readdata      (readdata)
    );

endmodule

//--- test/mem_test_tb.sv
`timescale 1ns/1ps

module mem_test_tb
    import mem_test_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 94661;

    // About 50 commands in all, each given at most 100 cycles to finish
    localparam int CMD_BUDGET = 50;
    localparam int CYCLES_PER_CMD = 100;
    localparam int WATCHDOG_NS = CMD_BUDGET * CYCLES_PER_CMD * CLK_PERIOD;

    logic                    clk;
    logic                    reset_n;
    logic                    sw_write;
    logic                    sw_read;
    logic [ADDR_WIDTH-1:0]   sw_address;
    logic [DATA_WIDTH-1:0]   sw_writedata;
    logic [BE_WIDTH-1:0]     sw_byteenable;
    logic [BURST_WIDTH-1:0]  sw_burstcount;
    logic                    mem_testmode;
    logic                    rdwr_reset;
    logic                    mem_error_clr;
    logic                    ready_for_sw_cmd;
    fsm_state_t              fsm_state;
    logic                    addr_test_done;
    logic                    addr_test_pass;
    logic [1:0]              rdwr_done;
    logic [DATA_WIDTH-1:0]   sw_readdata;
    logic [ERR_WIDTH-1:0]    mem_errors;

    // Reference memory and the words that the pending reads must return
    logic [DATA_WIDTH-1:0]   ref_mem [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0]   exp_reads [$];
    logic [ERR_WIDTH-1:0]    pred_errors;
    string                   test_name;

    mem_test_top u_mem_test_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .sw_write         (sw_write),
        .sw_read          (sw_read),
        .sw_address       (sw_address),
        .sw_writedata     (sw_writedata),
        .sw_byteenable    (sw_byteenable),
        .sw_burstcount    (sw_burstcount),
        .mem_testmode     (mem_testmode),
        .rdwr_reset       (rdwr_reset),
        .mem_error_clr    (mem_error_clr),
        .ready_for_sw_cmd (ready_for_sw_cmd),
        .fsm_state        (fsm_state),
        .addr_test_done   (addr_test_done),
        .addr_test_pass   (addr_test_pass),
        .rdwr_done        (rdwr_done),
        .sw_readdata      (sw_readdata),
        .mem_errors       (mem_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected)
        else stop_run($sformatf("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    function automatic logic [DATA_WIDTH-1:0] expand_mask(input logic [BE_WIDTH-1:0] be);
        logic [DATA_WIDTH-1:0] mask;
        for (int i = 0; i < BE_WIDTH; i++)
        begin
            mask[i*8 +: 8] = be[i] ? 8'hFF : 8'h00;
        end
        return mask;
    endfunction

    // Enabled bytes come from the new data and all others keep the old word
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] data,
                                                          input logic [BE_WIDTH-1:0] be);
        return (old_word & ~expand_mask(be)) | (data & expand_mask(be));
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready();
        while (!ready_for_sw_cmd)
            step();
    endtask

    task automatic wait_done(input int idx);
        while (!rdwr_done[idx])
            step();
    endtask

    task automatic issue_cmd(input mem_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [BE_WIDTH-1:0] be, input int beats);
        logic [ADDR_WIDTH-1:0] a;
        wait_ready();
        sw_address = addr;
        sw_writedata = data;
        sw_byteenable = be;
        sw_burstcount = BURST_WIDTH'(beats);
        sw_write = (op == OP_WRITE);
        sw_read = (op == OP_READ);
        // The model sees commands in issue order, like the command queue
        for (int i = 0; i < beats; i++)
        begin
            a = addr + ADDR_WIDTH'(i);
            if (op == OP_WRITE)
                ref_mem[a] = merge_bytes(ref_mem[a], data, be);
            else
                exp_reads.push_back(ref_mem[a]);
        end
        step();
        sw_write = 1'b0;
        sw_read = 1'b0;
    endtask

    task automatic clear_done();
        wait_ready();
        rdwr_reset = 1'b1;
        step();
        rdwr_reset = 1'b0;
        check_value("rdwr_done after rdwr_reset", '0, DATA_WIDTH'(rdwr_done));
    endtask

    task automatic check_reset_values();
        test_name = "reset_values";
        check_value("ready_for_sw_cmd", '0, DATA_WIDTH'(ready_for_sw_cmd));
        check_value("fsm_state", DATA_WIDTH'(IDLE), DATA_WIDTH'(fsm_state));
        check_value("addr_test_done", '0, DATA_WIDTH'(addr_test_done));
        check_value("addr_test_pass", '0, DATA_WIDTH'(addr_test_pass));
        check_value("rdwr_done", '0, DATA_WIDTH'(rdwr_done));
        check_value("mem_errors", '0, DATA_WIDTH'(mem_errors));
        check_value("cmd_valid", '0, DATA_WIDTH'(u_mem_test_top.cmd_valid));
        check_value("q_valid", '0, DATA_WIDTH'(u_mem_test_top.q_valid));
        check_value("readdatavalid", '0, DATA_WIDTH'(u_mem_test_top.readdatavalid));
    endtask

    task automatic write_then_read();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [ERR_WIDTH-1:0]  errors_before;
        int                    beats;
        test_name = "write_read";
        addr = ADDR_WIDTH'($urandom_range(252, 16));
        data = {$urandom, $urandom};
        beats = int'($urandom_range(4, 1));
        clear_done();
        errors_before = mem_errors;
        issue_cmd(OP_WRITE, addr, data, '1, beats);
        wait_done(0);
        check_value("read done ahead of read", '0, DATA_WIDTH'(rdwr_done[1]));
        issue_cmd(OP_READ, addr, data, '1, beats);
        wait_done(1);
        check_value("last read word", ref_mem[addr + ADDR_WIDTH'(beats - 1)], sw_readdata);
        check_value("error count", DATA_WIDTH'(errors_before), DATA_WIDTH'(mem_errors));
    endtask

    task automatic count_masked_errors();
        logic [ADDR_WIDTH-1:0] base;
        logic [DATA_WIDTH-1:0] full_data;
        logic [ERR_WIDTH-1:0]  exp_errors;
        test_name = "masked_errors";
        base = ADDR_WIDTH'($urandom_range(252, 16));
        full_data = {$urandom, $urandom};
        clear_done();
        issue_cmd(OP_WRITE, base, full_data, '1, 4);
        wait_done(0);
        clear_done();
        // Low four bytes of the first two words get the inverted pattern
        issue_cmd(OP_WRITE, base, ~full_data, 8'h0F, 2);
        wait_done(0);
        exp_errors = mem_errors;
        for (int i = 0; i < 4; i++)
        begin
            if (((ref_mem[base + ADDR_WIDTH'(i)] ^ full_data) & expand_mask(8'h3C)) != '0)
                exp_errors = exp_errors + ERR_WIDTH'(1);
        end
        issue_cmd(OP_READ, base, full_data, 8'h3C, 4);
        wait_done(1);
        check_value("masked error count", DATA_WIDTH'(exp_errors), DATA_WIDTH'(mem_errors));
    endtask

    task automatic clear_errors();
        test_name = "error_clear";
        check_value("rdwr_done ahead of clear", DATA_WIDTH'(2'b11), DATA_WIDTH'(rdwr_done));
        if (mem_errors == '0)
            stop_run("The error counter was already zero before mem_error_clr");
        wait_ready();
        mem_error_clr = 1'b1;
        step();
        mem_error_clr = 1'b0;
        check_value("error count after clear", '0, DATA_WIDTH'(mem_errors));
        clear_done();
    endtask

    task automatic run_address_test();
        logic [DATA_WIDTH-1:0] test_data;
        test_name = "address_test";
        test_data = {$urandom, $urandom};
        wait_ready();
        sw_writedata = test_data;
        sw_byteenable = '1;
        mem_testmode = 1'b1;
        for (int i = 0; i < 2**TEST_ADDR_BITS; i++)
        begin
            ref_mem[ADDR_WIDTH'(i)] = test_data;
            exp_reads.push_back(test_data);
        end
        while (!addr_test_done)
            step();
        check_value("addr_test_pass", DATA_WIDTH'(1), DATA_WIDTH'(addr_test_pass));
        // Test mode is still held, so a restart would be caught here
        repeat (10) step();
        for (int a = 0; a < 2**TEST_ADDR_BITS; a += 4)
        begin
            issue_cmd(OP_READ, ADDR_WIDTH'(a), test_data, '1, 4);
        end
        wait_ready();
        check_value("reads left", '0, DATA_WIDTH'(exp_reads.size()));
        check_value("last test word", test_data, sw_readdata);
        mem_testmode = 1'b0;
    endtask

    task automatic stream_back_to_back();
        logic [DATA_WIDTH-1:0] data [4];
        test_name = "back_to_back";
        for (int i = 0; i < 4; i++)
        begin
            data[i] = {$urandom, $urandom};
        end
        for (int i = 0; i < 4; i++)
        begin
            issue_cmd(OP_WRITE, ADDR_WIDTH'(128 + 4 * i), data[i], '1, 4);
        end
        for (int i = 0; i < 4; i++)
        begin
            issue_cmd(OP_READ, ADDR_WIDTH'(128 + 4 * i), data[i], '1, 4);
        end
        wait_ready();
        check_value("reads left", '0, DATA_WIDTH'(exp_reads.size()));
        check_value("last read word", data[3], sw_readdata);
    endtask

    // Every response is matched against the model, and the error count is predicted
    always @(negedge clk)
    begin : scoreboard
        logic [DATA_WIDTH-1:0] exp_word;
        if (!reset_n)
        begin
            pred_errors = '0;
        end
        else
        begin
            check_value("error counter", DATA_WIDTH'(pred_errors), DATA_WIDTH'(mem_errors));
            if (u_mem_test_top.readdatavalid)
            begin
                if (exp_reads.size() == 0)
                begin
                    stop_run("A read response arrived with no read outstanding");
                end
                else
                begin
                    exp_word = exp_reads.pop_front();
                    check_value("read data", exp_word, u_mem_test_top.readdata);
                    if (((exp_word ^ sw_writedata) & expand_mask(sw_byteenable)) != '0)
                        pred_errors = pred_errors + ERR_WIDTH'(1);
                end
            end
            if (mem_error_clr)
                pred_errors = '0;
        end
    end

    a_ready_only_in_idle: assert property (@(posedge clk) disable iff (!reset_n)
        ready_for_sw_cmd |-> fsm_state == IDLE)
        else stop_run("ready_for_sw_cmd was high outside IDLE");

    a_single_addr_test: assert property (@(posedge clk) disable iff (!reset_n)
        addr_test_done |-> (fsm_state != TEST_WRITE) && (fsm_state != TEST_READ))
        else stop_run("A second address test started");

    a_test_done_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        addr_test_done |=> addr_test_done)
        else stop_run("addr_test_done fell after it was set");

    a_pass_needs_done: assert property (@(posedge clk) disable iff (!reset_n)
        addr_test_pass |-> addr_test_done)
        else stop_run("addr_test_pass rose before addr_test_done");

    a_done_held_until_reset: assert property (@(posedge clk) disable iff (!reset_n)
        ($fell(rdwr_done[0]) || $fell(rdwr_done[1])) |-> $past(rdwr_reset))
        else stop_run("rdwr_done fell without rdwr_reset");

    initial
    begin
        #WATCHDOG_NS;
        stop_run("The watchdog expired before all tests finished");
    end

    initial
    begin : main
        void'($urandom(SEED));
        reset_n = 1'b0;
        sw_write = 1'b0;
        sw_read = 1'b0;
        sw_address = '0;
        sw_writedata = '0;
        sw_byteenable = '0;
        sw_burstcount = '0;
        mem_testmode = 1'b0;
        rdwr_reset = 1'b0;
        mem_error_clr = 1'b0;
        repeat (RESET_CYCLES) step();
        check_reset_values();
        reset_n = 1'b1;
        step();
        check_value("ready one cycle into IDLE", DATA_WIDTH'(1), DATA_WIDTH'(ready_for_sw_cmd));
        repeat (3) write_then_read();
        count_masked_errors();
        clear_errors();
        run_address_test();
        stream_back_to_back();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
logic/mem_test_pkg.sv
logic/mem_cmd_fsm.sv
logic/mem_cmd_fifo.sv
logic/local_mem_bank.sv
logic/mem_test_top.sv
test/mem_test_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= mem_test_tb
RTL_TOP    ?= mem_test_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
